// File: mont_settings.svh
`ifndef MONT_SETTINGS_SVH
`define MONT_SETTINGS_SVH

// ###################
// operand width W.
`define MONT_WIDTH 256

// counts 0 .. W, one bit of headroom.
`define MONT_CNT_W ($clog2(`MONT_WIDTH) + 1)

// chain length, up to 255 rounds.
`define MONT_ROUNDS_W 8

`endif

// File: mont_pkg.sv
`default_nettype none
`include "mont_settings.svh"

package mont_pkg;

    typedef logic [`MONT_WIDTH-1:0] mont_word_t;

    // one multiplication request.
    typedef struct packed {
        mont_word_t a;
        mont_word_t b;
        mont_word_t m; // odd modulus.
    } mont_req_t;

    // strobes from the multiplier FSM to the datapath.
    typedef struct packed {
        logic load;   // latch operands, clear accumulator.
        logic step;   // one radix-2 iteration.
        logic reduce; // final conditional subtraction.
    } mont_step_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_ITER,
        ST_REDUCE
    } mont_ctrl_state_e;

    typedef enum logic [1:0] {
        CH_IDLE,
        CH_ISSUE,
        CH_WAIT
    } mont_chain_state_e;

endpackage

`default_nettype wire

// File: mont_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "mont_settings.svh"

module mont_ctrl (
    input  wire                  clk,
    input  wire                  resetn,
    input  wire                  mult_start,
    output mont_pkg::mont_step_t step_ctl,
    output logic                 mult_done
);

    import mont_pkg::*;

    localparam logic [`MONT_CNT_W-1:0] LAST_ITER = `MONT_WIDTH - 1;

    mont_ctrl_state_e       state;
    logic [`MONT_CNT_W-1:0] iter_cnt;

    // ###################
    // load, W iterations, reduce.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= ST_IDLE;
            iter_cnt  <= '0;
            mult_done <= 1'b0;
        end else begin
            mult_done <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (mult_start) begin
                        state <= ST_LOAD;
                    end
                end

                ST_LOAD: begin
                    iter_cnt <= '0;
                    state    <= ST_ITER;
                end

                ST_ITER: begin
                    iter_cnt <= iter_cnt + 1'b1;
                    if (iter_cnt == LAST_ITER) begin // bit W-1 consumed.
                        state <= ST_REDUCE;
                    end
                end

                ST_REDUCE: begin
                    mult_done <= 1'b1; // prod registered this cycle.
                    state     <= ST_IDLE;
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // strobes decode straight from the state.
    assign step_ctl.load   = (state == ST_LOAD);
    assign step_ctl.step   = (state == ST_ITER);
    assign step_ctl.reduce = (state == ST_REDUCE);

endmodule

`default_nettype wire

// File: mont_operand_store.sv
`timescale 1ns/1ps
`default_nettype none

module mont_operand_store (
    input  wire                  clk,
    input  wire                  resetn,
    input  wire mont_pkg::mont_step_t step_ctl,
    input  wire mont_pkg::mont_req_t  mult_req,
    output logic                 a_bit,
    output mont_pkg::mont_word_t b,
    output mont_pkg::mont_word_t m
);

    import mont_pkg::*;

    mont_word_t a_sr;

    // a shifts out LSB first.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            a_sr <= '0;
        end else if (step_ctl.load) begin
            a_sr <= mult_req.a;
        end else if (step_ctl.step) begin
            a_sr <= a_sr >> 1;
        end
    end

    // b and m held for the whole product.
    always_ff @(posedge clk) begin
        if (step_ctl.load) begin
            b <= mult_req.b;
            m <= mult_req.m;
        end
    end

    assign a_bit = a_sr[0];

endmodule

`default_nettype wire

// File: mont_accum.sv
`timescale 1ns/1ps
`default_nettype none
`include "mont_settings.svh"

module mont_accum (
    input  wire                       clk,
    input  wire                       resetn,
    input  wire mont_pkg::mont_step_t step_ctl,
    input  wire                       a_bit,
    input  wire mont_pkg::mont_word_t b,
    input  wire mont_pkg::mont_word_t m,
    output logic [`MONT_WIDTH:0]      acc
);

    // acc < 2m and b < m, so three partial terms fit in W+2 bits.
    logic [`MONT_WIDTH+1:0] sum_ab;
    logic [`MONT_WIDTH+1:0] sum_qm;
    logic                   q;

    // ###################
    // one radix-2 iteration.
    always_comb begin
        sum_ab = {1'b0, acc} + (a_bit ? {2'b00, b} : '0);
        q      = sum_ab[0]; // makes the sum even.
        sum_qm = sum_ab + (q ? {2'b00, m} : '0);
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            acc <= '0;
        end else if (step_ctl.load) begin
            acc <= '0;
        end else if (step_ctl.step) begin
            acc <= sum_qm[`MONT_WIDTH+1:1]; // exact halving.
        end
    end

endmodule

`default_nettype wire

// File: mont_final_sub.sv
`timescale 1ns/1ps
`default_nettype none
`include "mont_settings.svh"

module mont_final_sub (
    input  wire                       clk,
    input  wire                       resetn,
    input  wire mont_pkg::mont_step_t step_ctl,
    input  wire [`MONT_WIDTH:0]       acc,
    input  wire mont_pkg::mont_word_t m,
    output mont_pkg::mont_word_t      prod
);

    logic [`MONT_WIDTH+1:0] diff;
    logic                   borrow;

    // borrow set means acc < m.
    assign diff   = {1'b0, acc} - {2'b00, m};
    assign borrow = diff[`MONT_WIDTH+1];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            prod <= '0;
        end else if (step_ctl.reduce) begin
            // acc < 2m, one subtraction is enough.
            prod <= borrow ? acc[`MONT_WIDTH-1:0] : diff[`MONT_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

// File: mont_chain_seq.sv
`timescale 1ns/1ps
`default_nettype none
`include "mont_settings.svh"

module mont_chain_seq (
    input  wire                       clk,
    input  wire                       resetn,
    input  wire                       start,
    input  wire mont_pkg::mont_req_t  req,
    input  wire [`MONT_ROUNDS_W-1:0]  rounds,
    input  wire                       mult_done,
    input  wire mont_pkg::mont_word_t prod,
    output logic                      busy,
    output logic                      done,
    output mont_pkg::mont_word_t      result,
    output logic                      mult_start,
    output mont_pkg::mont_req_t       mult_req
);

    import mont_pkg::*;

    mont_chain_state_e          state;
    logic [`MONT_ROUNDS_W-1:0]  rounds_left;
    logic                       accept;
    logic                       last_round;

    assign accept     = (state == CH_IDLE) && start && (rounds != '0);
    assign last_round = (rounds_left == `MONT_ROUNDS_W'(1));

    // ###################
    // round control.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state       <= CH_IDLE;
            rounds_left <= '0;
            done        <= 1'b0;
        end else begin
            done <= 1'b0;

            case (state)
                CH_IDLE: begin
                    if (accept) begin
                        rounds_left <= rounds;
                        state       <= CH_ISSUE;
                    end
                end

                CH_ISSUE: begin
                    state <= CH_WAIT; // strobe lasts one cycle.
                end

                CH_WAIT: begin
                    if (mult_done) begin
                        if (last_round) begin
                            done  <= 1'b1;
                            state <= CH_IDLE;
                        end else begin
                            rounds_left <= rounds_left - 1'b1;
                            state       <= CH_ISSUE;
                        end
                    end
                end

                default: begin
                    state <= CH_IDLE;
                end
            endcase
        end
    end

    // operand feedback, m held across rounds.
    always_ff @(posedge clk) begin
        if (accept) begin
            mult_req <= req;
        end else if (state == CH_WAIT && mult_done && !last_round) begin
            mult_req.a <= mult_req.b ^ prod;
            mult_req.b <= prod; // stays below m.
        end
    end

    always_ff @(posedge clk) begin
        if (state == CH_WAIT && mult_done && last_round) begin
            result <= prod;
        end
    end

    assign busy       = (state != CH_IDLE);
    assign mult_start = (state == CH_ISSUE);

endmodule

`default_nettype wire

// File: mont_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "mont_settings.svh"

module mont_top (
    input  wire                      clk,
    input  wire                      resetn,
    input  wire                      start,
    input  wire mont_pkg::mont_req_t req,
    input  wire [`MONT_ROUNDS_W-1:0] rounds,
    output logic                     busy,
    output logic                     done,
    output mont_pkg::mont_word_t     result
);

    import mont_pkg::*;

    logic                 mult_start;
    logic                 mult_done;
    mont_req_t            mult_req;
    mont_word_t           prod;
    mont_step_t           step_ctl;
    logic                 a_bit;
    mont_word_t           b;
    mont_word_t           m;
    logic [`MONT_WIDTH:0] acc;

    // ###################
    // round sequencer.
    mont_chain_seq chain_i (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .req        (req),
        .rounds     (rounds),
        .mult_done  (mult_done),
        .prod       (prod),
        .busy       (busy),
        .done       (done),
        .result     (result),
        .mult_start (mult_start),
        .mult_req   (mult_req)
    );

    // ###################
    // bit-serial multiplier.
    mont_ctrl ctrl_i (
        .clk        (clk),
        .resetn     (resetn),
        .mult_start (mult_start),
        .step_ctl   (step_ctl),
        .mult_done  (mult_done)
    );

    mont_operand_store store_i (
        .clk      (clk),
        .resetn   (resetn),
        .step_ctl (step_ctl),
        .mult_req (mult_req),
        .a_bit    (a_bit),
        .b        (b),
        .m        (m)
    );

    mont_accum accum_i (
        .clk      (clk),
        .resetn   (resetn),
        .step_ctl (step_ctl),
        .a_bit    (a_bit),
        .b        (b),
        .m        (m),
        .acc      (acc)
    );

    mont_final_sub sub_i (
        .clk      (clk),
        .resetn   (resetn),
        .step_ctl (step_ctl),
        .acc      (acc),
        .m        (m),
        .prod     (prod)
    );

endmodule

`default_nettype wire

// File: tb_mont_model.svh
`ifndef TB_MONT_MODEL_SVH
`define TB_MONT_MODEL_SVH

// ###################
// reference product a*b*2^-W mod m, radix 2 from the LSB of a.
function automatic mont_word_t mont_product(input mont_word_t a, input mont_word_t b,
                                            input mont_word_t m);
    logic [`MONT_WIDTH+1:0] t;
    t = '0;
    for (int i = 0; i < `MONT_WIDTH; i++) begin
        if (a[i]) begin
            t = t + b;
        end
        if (t[0]) begin
            t = t + m; // odd m makes t even.
        end
        t = t >> 1;
    end
    if (t >= m) begin
        t = t - m;
    end
    return t[`MONT_WIDTH-1:0];
endfunction

// round rule: a <= b ^ p, b <= p, m held.
function automatic mont_word_t chained_product(input mont_req_t r, input int n);
    mont_word_t a;
    mont_word_t b;
    mont_word_t p;
    a = r.a;
    b = r.b;
    p = '0;
    for (int k = 0; k < n; k++) begin
        p = mont_product(a, b, r.m);
        a = b ^ p;
        b = p;
    end
    return p;
endfunction

`endif

// File: tb_mont_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "mont_settings.svh"

module tb_mont_top;

    import mont_pkg::*;

    `include "tb_mont_model.svh"

    localparam int W            = `MONT_WIDTH;
    localparam int TOTAL_ROUNDS = 35;
    localparam int TOTAL_RUNS   = 17;
    localparam int TIMEOUT_CYCLES =
        TOTAL_ROUNDS * (W + 4) + TOTAL_RUNS * 4 + 2 * (W + 8) + 200;

    logic                      clk;
    logic                      resetn;
    logic                      start;
    mont_req_t                 req;
    logic [`MONT_ROUNDS_W-1:0] rounds;
    logic                      busy;
    logic                      done;
    mont_word_t                result;
    int                        cycle_cnt = 0;
    int                        done_cnt = 0;

    mont_top dut_i (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .req    (req),
        .rounds (rounds),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    always #20 clk = ~clk;

    always @(negedge clk) begin
        if (done) begin
            done_cnt++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            fail_run("done never arrived before the cycle limit");
        end
    end

    // ####################
    // helpers.
    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input mont_word_t got,
                               input mont_word_t expected);
        if (got !== expected) begin
            fail_run($sformatf("mismatch %s: got %0h expected %0h", name, got, expected));
        end
    endtask

    function automatic mont_word_t random_word();
        mont_word_t w;
        w = '0;
        for (int i = 0; i < W; i += 32) begin
            w = (w << 32) | $urandom;
        end
        return w;
    endfunction

    function automatic mont_req_t random_req();
        mont_req_t r;
        r.m = random_word() | 1; // modulus must be odd.
        r.a = random_word();
        r.b = random_word() % r.m;
        return r;
    endfunction

    task automatic start_run(input mont_req_t r, input int n);
        @(posedge clk);
        #2;
        req    = r;
        rounds = n;
        start  = 1'b1;
        @(posedge clk);
        #2;
        start  = 1'b0;
    endtask

    // called at a falling edge; returns at the falling edge where done is high.
    task automatic wait_done(input bit check_hold, input mont_word_t held);
        while (!done) begin
            if (check_hold) begin
                check_value("result", result, held);
            end
            @(negedge clk);
        end
    endtask

    task automatic run_and_check(input mont_req_t r, input int n, input bit check_hold);
        mont_word_t expected;
        mont_word_t held;
        expected = chained_product(r, n);
        held     = result;
        start_run(r, n);
        @(negedge clk);
        check_value("busy", busy, 1);
        wait_done(check_hold, held);
        check_value("result", result, expected);
        check_value("busy", busy, 0);
    endtask

    // ####################
    // directed tests.
    task automatic test_single_products();
        mont_req_t base;
        mont_req_t r;
        base = random_req();
        r = base;
        r.a = '0;
        run_and_check(r, 1, 0);
        r = base;
        r.a = 1;
        run_and_check(r, 1, 0);
        r = base;
        r.b = '0;
        run_and_check(r, 1, 0);
        r = base;
        r.b = base.m - 1;
        run_and_check(r, 1, 0);
        r.m = '1; // largest odd modulus.
        r.a = random_word();
        r.b = random_word() % r.m;
        run_and_check(r, 1, 0);
        repeat (4) begin
            run_and_check(random_req(), 1, 0);
        end
    endtask

    task automatic test_chained_rounds();
        run_and_check(random_req(), 2, 0);
        run_and_check(random_req(), 5, 0);
        run_and_check(random_req(), 12, 0);
    endtask

    task automatic test_zero_rounds();
        start_run(random_req(), 0);
        repeat (W + 8) begin
            @(negedge clk);
            if (busy || done) begin
                fail_run("a start with zero rounds was not ignored");
            end
        end
    endtask

    task automatic test_start_while_busy();
        mont_req_t  first;
        mont_word_t expected;
        int         dones_before;
        first        = random_req();
        expected     = chained_product(first, 1);
        dones_before = done_cnt;
        start_run(first, 1);
        repeat (4) @(posedge clk);
        start_run(random_req(), 1); // lands mid-product.
        @(negedge clk);
        wait_done(0, '0);
        check_value("result", result, expected);
        repeat (W + 8) @(negedge clk);
        @(posedge clk);
        if (done_cnt != dones_before + 1) begin
            fail_run("a start while busy produced another done");
        end
    endtask

    task automatic test_result_hold();
        run_and_check(random_req(), 2, 0);
        run_and_check(random_req(), 1, 1);
        run_and_check(random_req(), 3, 1);
    endtask

    initial begin
        void'($urandom(32'he25f));
        clk    = 1'b0;
        resetn = 1'b0;
        start  = 1'b0;
        req    = '0;
        rounds = '0;
        repeat (16) @(posedge clk);
        #2;
        resetn = 1'b1;
        @(negedge clk);
        check_value("busy", busy, 0);
        check_value("done", done, 0);

        test_single_products();
        test_chained_rounds();
        test_zero_rounds();
        test_start_while_busy();
        test_result_hold();

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
mont_pkg.sv
mont_ctrl.sv
mont_operand_store.sv
mont_accum.sv
mont_final_sub.sv
mont_chain_seq.sv
mont_top.sv
tb_mont_top.sv
